/* rtl/ctrlPkg.sv */
// Control unit package with opcode, funct and select codes shared by the pipeline control
`default_nettype none

package ctrlPkg;

  //////////////////////////////
  // Widths
  localparam int unsigned regAddrW = 5;           // Register address bits
  localparam int unsigned instrW   = 32;          // Instruction bits

  //////////////////////////////
  // Base opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;   // lb lh lw lbu lhu
  localparam logic [6:0] opImm    = 7'b0010011;   // I-type ALU
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opStore  = 7'b0100011;   // sb sh sw
  localparam logic [6:0] opReg    = 7'b0110011;   // R-type ALU and M extension
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opSystem = 7'b1110011;   // CSR and privileged

  // Funct7 patterns
  localparam logic [6:0] f7Base = 7'b0000000;     // Most R-type ops
  localparam logic [6:0] f7Alt  = 7'b0100000;     // sub, sra, srai
  localparam logic [6:0] f7Mul  = 7'b0000001;     // mul/div group

  //////////////////////////////
  // ALU and immediate selects
  localparam logic [2:0] aluSelAdd = 3'b000;      // Address generation

  localparam logic [2:0] immI = 3'd0;
  localparam logic [2:0] immS = 3'd1;
  localparam logic [2:0] immB = 3'd2;
  localparam logic [2:0] immJ = 3'd3;
  localparam logic [2:0] immU = 3'd4;

  // Writeback result source
  localparam logic [2:0] resAlu = 3'd0;
  localparam logic [2:0] resMem = 3'd1;
  localparam logic [2:0] resCsr = 3'd2;
  localparam logic [2:0] resMdu = 3'd3;
  localparam logic [2:0] resPc4 = 3'd4;           // Link address for jumps

  // Forwarding mux selects
  localparam logic [1:0] fwdNone = 2'd0;
  localparam logic [1:0] fwdWb   = 2'd1;
  localparam logic [1:0] fwdMem  = 2'd2;

  // Memory access, bit 1 read and bit 0 write
  localparam logic [1:0] memRead  = 2'b10;
  localparam logic [1:0] memWrite = 2'b01;

endpackage

`default_nettype wire

/* rtl/instrDecoder.sv */
// Decode-stage opcode decoder producing control fields, ALU controls and illegal flag
`default_nettype none
`timescale 1ns/1ps

module instrDecoder import ctrlPkg::*; #(
  parameter bit strictDecode = 1'b1,              // Exact funct checking
  parameter bit csrSupported = 1'b1               // Zicsr present
) (
  input  logic [instrW-1:0] instrD,               // Instruction in Decode
  output logic [2:0]        immSrcD,              // Immediate format
  output logic              regWriteD,
  output logic              aluSrcAD, aluSrcBD,   // PC / imm operand selects
  output logic [1:0]        memRWD,               // {read, write}
  output logic [2:0]        resultSrcD,
  output logic              branchD,
  output logic              jumpD,
  output logic              aluResultSrcD,        // Pass immediate through
  output logic [2:0]        aluSelectD,
  output logic              subArithD,            // Invert B operand
  output logic              csrReadD,
  output logic              csrWriteD,
  output logic              privilegedD,          // ecall, ebreak, mret and friends
  output logic              mduD,                 // Multiply or divide
  output logic              illegalBaseInstrD
);

  localparam int unsigned ctrlW = 19;
  localparam logic [ctrlW-1:0] ctrlIllegal = {{(ctrlW-1){1'b0}}, 1'b1};

  logic [6:0]       opD;
  logic [2:0]       funct3D;
  logic [6:0]       funct7D;
  logic [ctrlW-1:0] ctrlD;                        // Packed control word
  logic             aluOpD;                       // ALU op uses funct3
  logic             iFunctD, rFunctD, mFunctD;    // Legal funct per class
  logic             lFunctD, sFunctD, bFunctD;
  logic             jrFunctD, pFunctD, csrFunctD;
  logic             subD, sraD, sltD, sltuD;

  assign opD     = instrD[6:0];
  assign funct3D = instrD[14:12];
  assign funct7D = instrD[31:25];

  //////////////////////////////
  // Funct legality
  if (strictDecode) begin : gExact
    logic f7ZeroD, f7AltD, iShiftD;
    assign f7ZeroD   = (funct7D == f7Base);
    assign f7AltD    = (funct7D == f7Alt);
    assign iShiftD   = (funct3D == 3'b001 & f7ZeroD) | (funct3D == 3'b101 & (f7ZeroD | f7AltD));
    assign iFunctD   = iShiftD | (funct3D != 3'b001 & funct3D != 3'b101);
    assign rFunctD   = ((funct3D == 3'b000 | funct3D == 3'b101) & f7AltD) | f7ZeroD;
    assign mFunctD   = (funct7D == f7Mul);
    assign lFunctD   = (funct3D[1:0] != 2'b11) & (funct3D[2:1] != 2'b11); // No ld, lwu
    assign sFunctD   = (funct3D[2] == 1'b0) & (funct3D[1:0] != 2'b11);
    assign bFunctD   = (funct3D[2:1] != 2'b01);    // 010 and 011 reserved
    assign jrFunctD  = (funct3D == 3'b000);
    assign pFunctD   = (funct3D == 3'b000) & (instrD[11:7] == '0);
    assign csrFunctD = (funct3D[1:0] != 2'b00);
  end else begin : gCheap
    assign iFunctD   = 1'b1;
    assign rFunctD   = ~funct7D[0];                // Anything but a multiply
    assign mFunctD   = funct7D[0];
    assign lFunctD   = 1'b1;
    assign sFunctD   = 1'b1;
    assign bFunctD   = 1'b1;
    assign jrFunctD  = 1'b1;
    assign pFunctD   = (funct3D == 3'b000);        // Still splits privileged from CSR
    assign csrFunctD = 1'b1;
  end

  //////////////////////////////
  // Main decoder
  // regWrite_immSrc_srcAB_memRW_resultSrc_branch.aluOp.jump.aluRes_csr.priv.mdu_illegal
  always_comb begin
    ctrlD = ctrlIllegal;
    case (opD)
      opLoad:   if (lFunctD)  ctrlD = {1'b1, immI, 2'b01, memRead,  resMem, 4'b0000, 3'b000, 1'b0};
      opImm:    if (iFunctD)  ctrlD = {1'b1, immI, 2'b01, 2'b00,    resAlu, 4'b0100, 3'b000, 1'b0};
      opAuipc:                ctrlD = {1'b1, immU, 2'b11, 2'b00,    resAlu, 4'b0000, 3'b000, 1'b0};
      opStore:  if (sFunctD)  ctrlD = {1'b0, immS, 2'b01, memWrite, resAlu, 4'b0000, 3'b000, 1'b0};
      opReg:    if (rFunctD)  ctrlD = {1'b1, immI, 2'b00, 2'b00,    resAlu, 4'b0100, 3'b000, 1'b0};
                else if (mFunctD)
                              ctrlD = {1'b1, immI, 2'b00, 2'b00,    resMdu, 4'b0000, 3'b001, 1'b0};
      opLui:                  ctrlD = {1'b1, immU, 2'b01, 2'b00,    resAlu, 4'b0001, 3'b000, 1'b0};
      opBranch: if (bFunctD)  ctrlD = {1'b0, immB, 2'b11, 2'b00,    resAlu, 4'b1000, 3'b000, 1'b0};
      opJalr:   if (jrFunctD) ctrlD = {1'b1, immI, 2'b01, 2'b00,    resPc4, 4'b0010, 3'b000, 1'b0};
      opJal:                  ctrlD = {1'b1, immJ, 2'b11, 2'b00,    resPc4, 4'b0010, 3'b000, 1'b0};
      opSystem: if (csrSupported) begin
                  if (pFunctD)                     // Handed to privilege decode
                              ctrlD = {1'b0, immI, 2'b00, 2'b00,    resAlu, 4'b0000, 3'b010, 1'b0};
                  else if (csrFunctD)
                              ctrlD = {1'b1, immI, 2'b00, 2'b00,    resCsr, 4'b0000, 3'b100, 1'b0};
                end
      default:                ctrlD = ctrlIllegal;
    endcase
  end

  assign {regWriteD, immSrcD, aluSrcAD, aluSrcBD, memRWD, resultSrcD, branchD, aluOpD,
          jumpD, aluResultSrcD, csrReadD, privilegedD, mduD, illegalBaseInstrD} = ctrlD;

  // Set/clear with x0 or zero immediate only reads
  assign csrWriteD = csrReadD & ~((instrD[19:15] == '0) & instrD[13]);

  // ALU controls, funct7 bit 5 alone splits add/sub and srl/sra
  assign subD       = (funct3D == 3'b000) & funct7D[5] & opD[5]; // opD[5] excludes addi
  assign sraD       = (funct3D == 3'b101) & funct7D[5];
  assign sltD       = (funct3D == 3'b010);
  assign sltuD      = (funct3D == 3'b011);
  assign subArithD  = aluOpD & (subD | sraD | sltD | sltuD);
  assign aluSelectD = aluOpD ? funct3D : aluSelAdd;  // Add for address generation

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
// Forwarding selects for Execute operands and Decode-stage structural stall detection
`default_nettype none
`timescale 1ns/1ps

module hazardUnit import ctrlPkg::*; (
  input  logic [regAddrW-1:0] rs1D, rs2D,
  input  logic [1:0]          memRWD,
  input  logic [regAddrW-1:0] rs1E, rs2E, rdE,
  input  logic [1:0]          memRWE,
  input  logic                csrReadE,
  input  logic                mduActiveE,
  input  logic [regAddrW-1:0] rdM,
  input  logic                regWriteM,
  input  logic [regAddrW-1:0] rdW,
  input  logic                regWriteW,
  output logic [1:0]          forwardAE, forwardBE,
  output logic                loadStallD,
  output logic                storeStallD,
  output logic                structuralStallD
);

  logic matchDE;                                  // Decode source hits Execute dest
  logic csrRdStallD, mduStallD;

  // Newest producer wins, x0 never forwarded
  function automatic logic [1:0] fwdSel(input logic [regAddrW-1:0] rs,
                                        input logic [regAddrW-1:0] rdMem, input logic wrMem,
                                        input logic [regAddrW-1:0] rdWb, input logic wrWb);
    logic [1:0] sel;
    sel = fwdNone;
    if (rs != '0) begin
      if (wrMem & (rs == rdMem))    sel = fwdMem;
      else if (wrWb & (rs == rdWb)) sel = fwdWb;
    end
    return sel;
  endfunction

  assign forwardAE = fwdSel(rs1E, rdM, regWriteM, rdW, regWriteW);
  assign forwardBE = fwdSel(rs2E, rdM, regWriteM, rdW, regWriteW);

  //////////////////////////////
  // Results not ready for bypass out of Execute
  assign matchDE     = ((rs1D == rdE) | (rs2D == rdE)) & (rdE != '0);
  assign loadStallD  = memRWE[1] & matchDE;
  assign storeStallD = memRWD[1] & memRWE[0];          // Load right behind a store
  assign csrRdStallD = csrReadE & matchDE;
  assign mduStallD   = mduActiveE & matchDE;           // Multicycle MDU result
  assign structuralStallD = loadStallD | storeStallD | csrRdStallD | mduStallD;

endmodule

`default_nettype wire

/* rtl/stageRegs.sv */
// Execute, Memory and Writeback control registers with branch resolution in Execute
`default_nettype none
`timescale 1ns/1ps

module stageRegs import ctrlPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                stallD, flushD,
  input  logic                stallE, flushE,
  input  logic                stallM, flushM,
  input  logic                stallW, flushW,
  input  logic                regWriteD,
  input  logic                aluSrcAD, aluSrcBD,
  input  logic [1:0]          memRWD,
  input  logic [2:0]          resultSrcD,
  input  logic                branchD, jumpD,
  input  logic                aluResultSrcD,
  input  logic [2:0]          aluSelectD,
  input  logic                subArithD,
  input  logic                csrReadD, csrWriteD, privilegedD,
  input  logic                mduD,
  input  logic [instrW-1:0]   instrD,
  input  logic [1:0]          flagsE,               // {eq, lt} from comparator
  output logic                instrValidD, instrValidE, instrValidM,
  output logic                aluSrcAE, aluSrcBE, aluResultSrcE,
  output logic [2:0]          aluSelectE,
  output logic [2:0]          funct3E,
  output logic                subArithE,
  output logic                jumpE, branchE, branchSignedE,
  output logic                pcSrcE,               // Redirect fetch
  output logic [1:0]          memRWE, memRWM,
  output logic                mduActiveE, intDivE, intDivW,
  output logic                regWriteM, regWriteW,
  output logic [2:0]          resultSrcW,
  output logic                csrReadE, csrReadM, csrWriteM, privilegedM,
  output logic [2:0]          funct3M,
  output logic [regAddrW-1:0] rs1E, rs2E,
  output logic [regAddrW-1:0] rdE, rdM, rdW
);

  logic       regWriteE;
  logic [2:0] resultSrcE, resultSrcM;
  logic       csrWriteE, privilegedE;
  logic       mduE, intDivM;
  logic       eqE, ltE;
  logic       branchFlagE;                            // eq or lt per funct3

  // Decode valid, set by any advancing edge
  always_ff @(posedge clk) begin
    if (reset | flushD) instrValidD <= 1'b0;
    else if (~stallD)   instrValidD <= 1'b1;
  end

  //////////////////////////////
  // Execute register
  always_ff @(posedge clk) begin
    if (reset | flushE) begin
      {aluSelectE, regWriteE, resultSrcE, memRWE, jumpE, branchE, aluSrcAE, aluSrcBE,
       aluResultSrcE, csrReadE, csrWriteE, privilegedE, funct3E, subArithE, mduE,
       instrValidE, rs1E, rs2E, rdE} <= '0;
    end else if (~stallE) begin
      {aluSelectE, regWriteE, resultSrcE, memRWE, jumpE, branchE, aluSrcAE, aluSrcBE,
       aluResultSrcE, csrReadE, csrWriteE, privilegedE, funct3E, subArithE, mduE,
       instrValidE, rs1E, rs2E, rdE} <=
      {aluSelectD, regWriteD, resultSrcD, memRWD, jumpD, branchD, aluSrcAD, aluSrcBD,
       aluResultSrcD, csrReadD, csrWriteD, privilegedD, instrD[14:12], subArithD, mduD,
       instrValidD, instrD[19:15], instrD[24:20], instrD[11:7]};
    end
  end

  // Branch resolution, comparator gives only eq and lt
  assign {eqE, ltE}    = flagsE;
  assign branchFlagE   = funct3E[2] ? ltE : eqE;                 // blt/bge vs beq/bne
  assign pcSrcE        = jumpE | (branchE & (branchFlagE ^ funct3E[0])); // Odd funct3 inverts
  assign branchSignedE = branchE & (funct3E[2:1] != 2'b11);      // Not bltu/bgeu

  assign mduActiveE = (resultSrcE == resMdu);
  assign intDivE    = mduE & funct3E[2];                         // div, divu, rem, remu

  //////////////////////////////
  // Memory register
  always_ff @(posedge clk) begin
    if (reset | flushM) begin
      {regWriteM, resultSrcM, memRWM, csrReadM, csrWriteM, privilegedM, funct3M,
       instrValidM, intDivM, rdM} <= '0;
    end else if (~stallM) begin
      {regWriteM, resultSrcM, memRWM, csrReadM, csrWriteM, privilegedM, funct3M,
       instrValidM, intDivM, rdM} <=
      {regWriteE, resultSrcE, memRWE, csrReadE, csrWriteE, privilegedE, funct3E,
       instrValidE, intDivE, rdE};
    end
  end

  // Writeback register
  always_ff @(posedge clk) begin
    if (reset | flushW)
      {regWriteW, resultSrcW, intDivW, rdW} <= '0;
    else if (~stallW)
      {regWriteW, resultSrcW, intDivW, rdW} <= {regWriteM, resultSrcM, intDivM, rdM};
  end

endmodule

`default_nettype wire

/* rtl/controller.sv */
// Pipeline control unit top joining the decoder, stage registers and hazard logic
`default_nettype none
`timescale 1ns/1ps

module controller import ctrlPkg::*; #(
  parameter bit strictDecode = 1'b1,
  parameter bit csrSupported = 1'b1
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [instrW-1:0]   instrD,
  input  logic [1:0]          flagsE,               // {eq, lt}
  input  logic                stallD, flushD, stallE, flushE,
  input  logic                stallM, flushM, stallW, flushW,
  output logic [regAddrW-1:0] rs1D, rs2D,
  output logic [2:0]          immSrcD,
  output logic                illegalBaseInstrD,
  output logic                jumpD, branchD,
  output logic                structuralStallD, loadStallD, storeStallD,
  output logic                instrValidD, instrValidE, instrValidM,
  output logic                aluSrcAE, aluSrcBE, aluResultSrcE,
  output logic [2:0]          aluSelectE, funct3E,
  output logic                subArithE,
  output logic                jumpE, branchE, branchSignedE, pcSrcE,
  output logic [1:0]          memRWE, memRWM,
  output logic                mduActiveE, intDivE, intDivW,
  output logic                regWriteM, regWriteW,
  output logic [2:0]          resultSrcW,
  output logic                csrReadE, csrReadM, csrWriteM, privilegedM,
  output logic [2:0]          funct3M,
  output logic [regAddrW-1:0] rs1E, rs2E, rdE, rdM, rdW,
  output logic [1:0]          forwardAE, forwardBE  // Operand bypass selects
);

  logic       regWriteD, aluSrcAD, aluSrcBD, aluResultSrcD;
  logic [1:0] memRWD;
  logic [2:0] resultSrcD, aluSelectD;
  logic       subArithD, csrReadD, csrWriteD, privilegedD, mduD;

  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];

  instrDecoder #(.strictDecode(strictDecode), .csrSupported(csrSupported)) u_decoder (
    .instrD, .immSrcD, .regWriteD, .aluSrcAD, .aluSrcBD, .memRWD, .resultSrcD,
    .branchD, .jumpD, .aluResultSrcD, .aluSelectD, .subArithD, .csrReadD,
    .csrWriteD, .privilegedD, .mduD, .illegalBaseInstrD);

  stageRegs u_stageRegs (
    .clk, .reset, .stallD, .flushD, .stallE, .flushE, .stallM, .flushM, .stallW, .flushW,
    .regWriteD, .aluSrcAD, .aluSrcBD, .memRWD, .resultSrcD, .branchD, .jumpD,
    .aluResultSrcD, .aluSelectD, .subArithD, .csrReadD, .csrWriteD, .privilegedD, .mduD,
    .instrD, .flagsE,
    .instrValidD, .instrValidE, .instrValidM, .aluSrcAE, .aluSrcBE, .aluResultSrcE,
    .aluSelectE, .funct3E, .subArithE, .jumpE, .branchE, .branchSignedE, .pcSrcE,
    .memRWE, .memRWM, .mduActiveE, .intDivE, .intDivW, .regWriteM, .regWriteW,
    .resultSrcW, .csrReadE, .csrReadM, .csrWriteM, .privilegedM, .funct3M,
    .rs1E, .rs2E, .rdE, .rdM, .rdW);

  hazardUnit u_hazard (
    .rs1D, .rs2D, .memRWD, .rs1E, .rs2E, .rdE, .memRWE, .csrReadE, .mduActiveE,
    .rdM, .regWriteM, .rdW, .regWriteW,
    .forwardAE, .forwardBE, .loadStallD, .storeStallD, .structuralStallD);

endmodule

`default_nettype wire

/* dv/controllerTb.sv */
// Testbench for the pipeline control unit with a shadow stage model and property checks
`default_nettype none
`timescale 1ns/1ps

module controllerTb import ctrlPkg::*; ();

  localparam int resetCycles   = 10;
  localparam int phaseCycles   = 300;
  localparam int numPhases     = 4;                 // Clean, stalls, flushes, both
  localparam int runCycles     = resetCycles + numPhases * phaseCycles;
  localparam int timeoutCycles = runCycles + runCycles * 2 / 3;   // About 2000
  localparam int numEntries    = 20;
  // Low two bits of rd, rs1 and rs2, so sources hit x0..x3 often
  localparam logic [31:0] fRd  = 32'h00000180;
  localparam logic [31:0] fRs1 = 32'h00018000;
  localparam logic [31:0] fRs2 = 32'h00300000;
  localparam logic [31:0] fAll = fRd | fRs1 | fRs2;

  typedef struct packed {
    logic [1:0] memRW;
    logic [2:0] res;
    logic [2:0] imm;                                // Immediate format
    logic       srcA, srcB, aluRes, aluOp, priv;
    logic       branch, jump, csrRd, csrWr, regWr, illegal;
  } ctlT;

  typedef struct packed {
    logic [31:0] base;                              // Encoding with free fields zero
    logic [31:0] free;                              // Bits open to randomization
    ctlT         ctl;                               // Expected decode
  } entryT;

  logic clk = 1'b0;
  logic reset;
  logic [instrW-1:0] instrD;
  logic [1:0] flagsE;                               // {eq, lt}
  logic stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  logic [regAddrW-1:0] rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
  logic [2:0] immSrcD, aluSelectE, funct3E, resultSrcW, funct3M;
  logic illegalBaseInstrD, jumpD, branchD, structuralStallD, loadStallD, storeStallD;
  logic instrValidD, instrValidE, instrValidM, aluSrcAE, aluSrcBE, aluResultSrcE, subArithE;
  logic jumpE, branchE, branchSignedE, pcSrcE, mduActiveE, intDivE, intDivW;
  logic [1:0] memRWE, memRWM, forwardAE, forwardBE;
  logic regWriteM, regWriteW, csrReadE, csrReadM, csrWriteM, privilegedM;

  entryT instrTable [numEntries];
  ctlT shCtlD, shCtlE, shCtlM, shCtlW;              // Shadow controls per stage
  logic [31:0] shInstrE;
  logic [regAddrW-1:0] shRdM, shRdW;
  logic [2:0] shF3M, shF3W;                         // funct3 carried past Execute
  logic shValidD, shValidE, shValidM;
  logic [31:0] expD, expE, expOp, expM, expW, expBr, expFwd, expHz;
  logic [31:0] actD, actE, actOp, actM, actW, actBr, actFwd, actHz, actRst;
  int cycles = 0;

  controller #(.strictDecode(1'b1), .csrSupported(1'b1)) uut (.*);

  always #2 clk = ~clk;                             // 4 ns period

  task automatic reportMismatch(input string testName, input logic [31:0] expVal, actVal);
    $display("error %s: expected %0h, actual %0h", testName, expVal, actVal);
    $display("TESTBENCH FAILED");
    $fatal(1, "Check %s failed", testName);
  endtask

  // M beats W, x0 never bypassed
  function automatic logic [1:0] expectForward(input logic [regAddrW-1:0] src);
    if (src == '0) return fwdNone;
    if (shCtlM.regWr && src == shRdM) return fwdMem;
    if (shCtlW.regWr && src == shRdW) return fwdWb;
    return fwdNone;
  endfunction

  //////////////////////////////
  // Shadow pipeline, same stall and flush rule as the DUT
  always @(posedge clk) begin
    if (reset || flushD) shValidD <= 1'b0;
    else if (!stallD) shValidD <= 1'b1;
    if (reset || flushE) begin                      // Flush wins over stall
      shCtlE   <= '0;
      shInstrE <= '0;
      shValidE <= 1'b0;
    end else if (!stallE) begin
      shCtlE   <= shCtlD;
      shInstrE <= instrD;
      shValidE <= shValidD;
    end
    if (reset || flushM) begin
      shCtlM   <= '0;
      shRdM    <= '0;
      shF3M    <= '0;
      shValidM <= 1'b0;
    end else if (!stallM) begin
      shCtlM   <= shCtlE;
      shRdM    <= shInstrE[11:7];
      shF3M    <= shInstrE[14:12];
      shValidM <= shValidE;
    end
    if (reset || flushW) begin
      shCtlW <= '0;
      shRdW  <= '0;
      shF3W  <= '0;
    end else if (!stallW) begin
      shCtlW <= shCtlM;
      shRdW  <= shRdM;
      shF3W  <= shF3M;
    end
  end

  // Expected outputs from the shadow state and the Decode instruction
  always_comb begin
    logic [regAddrW-1:0] rdShE;
    logic [2:0] f3E;
    logic matchE, loadHit, storeHit, flagSel, subHit;
    rdShE    = shInstrE[11:7];
    f3E      = shInstrE[14:12];
    matchE   = (rdShE != '0) && (instrD[19:15] == rdShE || instrD[24:20] == rdShE);
    loadHit  = shCtlE.memRW[1] && matchE;
    storeHit = shCtlD.memRW[1] && shCtlE.memRW[0];  // Load behind a store
    flagSel  = shInstrE[14] ? flagsE[0] : flagsE[1];
    // sub, sra, slt and sltu
    subHit   = (((f3E == 3'b000) && (shInstrE[6:0] == opReg)) || (f3E == 3'b101))
               && (shInstrE[31:25] == f7Alt) || (f3E == 3'b010) || (f3E == 3'b011);
    expD = 32'({shCtlD.imm, shCtlD.jump, shCtlD.branch, shCtlD.illegal, shValidD,
                instrD[19:15], instrD[24:20]});
    expE = 32'({shCtlE.memRW, shCtlE.branch, shCtlE.jump, shCtlE.res == resMdu,
                shCtlE.csrRd, shInstrE[14:12], rdShE, shValidE});
    expOp = 32'({shCtlE.srcA, shCtlE.srcB, shCtlE.aluRes, shCtlE.aluOp ? f3E : aluSelAdd,
                 shCtlE.aluOp && subHit, (shCtlE.res == resMdu) && f3E[2],
                 shInstrE[19:15], shInstrE[24:20]});
    expM = 32'({shCtlM.memRW, shCtlM.regWr, shCtlM.csrRd, shCtlM.csrWr, shRdM, shValidM,
                shCtlM.priv, shF3M});
    expW = 32'({shCtlW.regWr, shCtlW.res, shRdW, (shCtlW.res == resMdu) && shF3W[2]});
    expBr = 32'({shCtlE.jump || (shCtlE.branch && (flagSel ^ shInstrE[12])),
                 shCtlE.branch && (shInstrE[14:13] != 2'b11)});
    expFwd = 32'({expectForward(shInstrE[19:15]), expectForward(shInstrE[24:20])});
    expHz = 32'({loadHit, storeHit,
                 loadHit || storeHit || (matchE && (shCtlE.csrRd || shCtlE.res == resMdu))});
  end

  assign actD   = 32'({immSrcD, jumpD, branchD, illegalBaseInstrD, instrValidD, rs1D, rs2D});
  assign actE   = 32'({memRWE, branchE, jumpE, mduActiveE, csrReadE, funct3E, rdE, instrValidE});
  assign actOp  = 32'({aluSrcAE, aluSrcBE, aluResultSrcE, aluSelectE, subArithE, intDivE,
                       rs1E, rs2E});
  assign actM   = 32'({memRWM, regWriteM, csrReadM, csrWriteM, rdM, instrValidM,
                       privilegedM, funct3M});
  assign actW   = 32'({regWriteW, resultSrcW, rdW, intDivW});
  assign actBr  = 32'({pcSrcE, branchSignedE});
  assign actFwd = 32'({forwardAE, forwardBE});
  assign actHz  = 32'({loadStallD, storeStallD, structuralStallD});
  assign actRst = 32'({instrValidE, instrValidM, regWriteW, memRWE, memRWM, csrWriteM, pcSrcE});

  //////////////////////////////
  // Checks on the falling edge, inputs settle on the rising one
  assert property (@(negedge clk) reset |-> actRst == '0)
    else reportMismatch("reset", 32'd0, actRst);
  assert property (@(negedge clk) actD == expD) else reportMismatch("decode", expD, actD);
  assert property (@(negedge clk) actE == expE) else reportMismatch("execute stage", expE, actE);
  assert property (@(negedge clk) actOp == expOp)
    else reportMismatch("execute operands", expOp, actOp);
  assert property (@(negedge clk) actM == expM) else reportMismatch("memory stage", expM, actM);
  assert property (@(negedge clk) actW == expW) else reportMismatch("writeback stage", expW, actW);
  assert property (@(negedge clk) actBr == expBr) else reportMismatch("branch", expBr, actBr);
  assert property (@(negedge clk) actFwd == expFwd) else reportMismatch("forward", expFwd, actFwd);
  assert property (@(negedge clk) actHz == expHz) else reportMismatch("hazard", expHz, actHz);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeoutCycles) begin
      $display("Run did not finish within %0d cycles", timeoutCycles);
      $display("TESTBENCH FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    logic [4:0] idx;
    void'($urandom(32'h2d73582e));
    // Columns are memRW, result, imm, then srcA srcB aluRes aluOp priv,
    // then branch jump csrRd csrWr regWr illegal
    instrTable[0]  = {32'h00002003, fAll, memRead, resMem, immI, 5'b01000, 6'b000010};  // lw
    instrTable[1]  = {32'h00002023, fAll, memWrite, resAlu, immS, 5'b01000, 6'b000000}; // sw
    instrTable[2]  = {32'h00003023, fAll, 2'b00, resAlu, immI, 5'b00000, 6'b000001};    // sd
    instrTable[3]  = {32'h00000013, fAll, 2'b00, resAlu, immI, 5'b01010, 6'b000010};    // addi
    instrTable[4]  = {32'h40001013, fAll, 2'b00, resAlu, immI, 5'b00000, 6'b000001};    // slli
    instrTable[5]  = {32'h40000033, fAll, 2'b00, resAlu, immI, 5'b00010, 6'b000010};    // sub
    instrTable[6]  = {32'h02000033, fAll, 2'b00, resMdu, immI, 5'b00000, 6'b000010};    // mul
    instrTable[7]  = {32'h02005033, fAll, 2'b00, resMdu, immI, 5'b00000, 6'b000010};    // divu
    instrTable[8]  = {32'h20000033, fAll, 2'b00, resAlu, immI, 5'b00000, 6'b000001};    // Bad f7
    instrTable[9]  = {32'h00000037, fAll, 2'b00, resAlu, immU, 5'b01100, 6'b000010};    // lui
    instrTable[10] = {32'h00000063, fAll, 2'b00, resAlu, immB, 5'b11000, 6'b100000};    // beq
    instrTable[11] = {32'h00004063, fAll, 2'b00, resAlu, immB, 5'b11000, 6'b100000};    // blt
    instrTable[12] = {32'h00007063, fAll, 2'b00, resAlu, immB, 5'b11000, 6'b100000};    // bgeu
    instrTable[13] = {32'h0000006f, fAll, 2'b00, resPc4, immJ, 5'b11000, 6'b010010};    // jal
    instrTable[14] = {32'h00000067, fAll, 2'b00, resPc4, immI, 5'b01000, 6'b010010};    // jalr
    instrTable[15] = {32'h0000000b, fAll, 2'b00, resAlu, immI, 5'b00000, 6'b000001};    // custom-0
    instrTable[16] = {32'h00001073, fAll, 2'b00, resCsr, immI, 5'b00000, 6'b001110};    // csrrw
    instrTable[17] = {32'h00002073, fRd | fRs2, 2'b00, resCsr, immI, 5'b00000, 6'b001010};
    instrTable[18] = {32'h0002e073, fRd | fRs2, 2'b00, resCsr, immI, 5'b00000, 6'b001110};
    instrTable[19] = {32'h00000073, fRs1 | fRs2, 2'b00, resAlu, immI, 5'b00001, 6'b000000};
    reset  = 1'b1;
    instrD = instrTable[3].base;
    shCtlD = instrTable[3].ctl;
    flagsE = 2'b00;
    {stallD, stallE, stallM, stallW} = 4'b0;
    {flushD, flushE, flushM, flushW} = 4'b0;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    for (int phase = 0; phase < numPhases; phase++) begin
      repeat (phaseCycles) begin
        @(posedge clk);
        idx = 5'($urandom % numEntries);
        instrD <= instrTable[idx].base | ($urandom & instrTable[idx].free);
        shCtlD <= instrTable[idx].ctl;
        flagsE <= 2'($urandom);
        {stallD, stallE, stallM, stallW} <= phase[0] ? 4'($urandom & $urandom) : 4'b0;
        {flushD, flushE, flushM, flushW} <= phase[1] ? 4'($urandom & $urandom & $urandom) : 4'b0;
      end
    end
    @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/hazardUnit.sv
rtl/stageRegs.sv
rtl/controller.sv
dv/controllerTb.sv

/* Makefile */
# Verilator flow for the pipeline control unit testbench

VERILATOR ?= verilator
TOP       ?= controllerTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
